/* Makefile */
VERILATOR ?= verilator
TOP       ?= dac_bist_tb
RTL_TOP   ?= dac_bist_top
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= all tests passed
VFLAGS    ?= --timing
SIM_FLAGS ?= --binary --assert -j 0

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) $(VFLAGS) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# The log decides pass or fail
sim: build
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "FAIL: pass line missing in $(LOG)"; exit 1; }
	@echo "PASS"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* awg/awg_bus_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dac_config.svh"

module awg_bus_regs import dac_pkg::*; (
    input  wire           dac_clk_out,
    input  wire           rst_n_i,
    // Wishbone classic slave
    input  wire           wb_cyc_i,
    input  wire           wb_stb_i,
    input  wire           wb_we_i,
    input  wire wb_addr_t wb_adr_i,
    input  wire wb_data_t wb_dat_i,
    output wb_data_t      wb_dat_o,
    output logic          wb_ack_o,
    // Towards the waveform buffer and the output mux
    awg_ctrl_if.regs_mp   ctrl_o,
    dac_route_if.regs_mp  route_o
);

    localparam int CTRL_W = `CTRL_BIT_PLAY + 1;

    logic              bus_req;
    logic              sel_ctrl;
    logic              sel_length;
    logic              sel_mem;
    wb_addr_t          mem_offset;
    wb_data_t          rd_data;
    logic [CTRL_W-1:0] ctrl_q;
    awg_addr_t         length_q;

    // ------------------------------------------------
    // Request and address decode
    // ------------------------------------------------
    // New request only while no ack is pending
    assign bus_req = wb_cyc_i & wb_stb_i & ~wb_ack_o;

    assign sel_ctrl   = (wb_adr_i == `REG_CTRL);
    assign sel_length = (wb_adr_i == `REG_LENGTH);
    // Offset wraps below the base, so one compare covers the window
    assign mem_offset = wb_adr_i - `AWG_MEM_BASE;
    assign sel_mem    = (mem_offset < wb_addr_t'(1 << `AWG_ADDR_W));

    // Readable registers, everything else reads as zero
    always_comb begin
        rd_data = '0;
        if (sel_ctrl) begin
            rd_data = wb_data_t'(ctrl_q);
        end else if (sel_length) begin
            rd_data = wb_data_t'(length_q);
        end
    end

    // ------------------------------------------------
    // Ack, registers and write strobe
    // ------------------------------------------------
    always_ff @(posedge dac_clk_out or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wb_ack_o     <= 1'b0;
            ctrl_q       <= '0;
            length_q     <= '0;
            ctrl_o.wr_en <= 1'b0;
        end else begin
            // Every address acks, one cycle after the request
            wb_ack_o     <= bus_req;
            ctrl_o.wr_en <= bus_req & wb_we_i & sel_mem;
            if (bus_req && wb_we_i && sel_ctrl) begin
                ctrl_q <= wb_dat_i[CTRL_W-1:0];
            end
            if (bus_req && wb_we_i && sel_length) begin
                length_q <= wb_dat_i[`AWG_ADDR_W-1:0];
            end
        end
    end

    // Write payload and read data, qualified by wr_en and ack
    always_ff @(posedge dac_clk_out) begin
        if (bus_req) begin
            ctrl_o.wr_addr <= mem_offset[`AWG_ADDR_W-1:0];
            ctrl_o.wr_data <= wb_dat_i[`DAC_W-1:0];
            wb_dat_o       <= wb_we_i ? '0 : rd_data;
        end
    end

    // ------------------------------------------------
    // Control bit fan-out
    // ------------------------------------------------
    assign ctrl_o.play_en    = ctrl_q[`CTRL_BIT_PLAY];
    assign ctrl_o.play_last  = length_q;

    assign route_o.dac0_en      = ctrl_q[`CTRL_BIT_DAC0_EN];
    assign route_o.dac0_src_awg = ctrl_q[`CTRL_BIT_DAC0_SRC];
    assign route_o.dac1_en      = ctrl_q[`CTRL_BIT_DAC1_EN];
    assign route_o.dac1_src_awg = ctrl_q[`CTRL_BIT_DAC1_SRC];

endmodule

`default_nettype wire

/* awg/awg_sample_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dac_config.svh"

module awg_sample_buffer import dac_pkg::*; (
    input  wire        dac_clk_out,
    input  wire        rst_n_i,
    awg_ctrl_if.buf_mp ctrl_i,
    output dac_word_t  awg_sample_o
);

    localparam int DEPTH = 1 << `AWG_ADDR_W;

    dac_word_t   mem [DEPTH];
    play_state_t state_q;
    play_state_t state_d;
    awg_addr_t   rd_idx_q;
    awg_addr_t   rd_idx_d;
    awg_addr_t   rd_idx_next;
    dac_word_t   sample_d;

    // ------------------------------------------------
    // Sample memory write port
    // ------------------------------------------------
    always_ff @(posedge dac_clk_out) begin
        if (ctrl_i.wr_en) begin
            mem[ctrl_i.wr_addr] <= ctrl_i.wr_data;
        end
    end

    // ------------------------------------------------
    // Looping read sequencer
    // ------------------------------------------------
    // Wrap after the last sample
    // Greater-or-equal also recovers if play_last shrinks mid loop
    assign rd_idx_next = (rd_idx_q >= ctrl_i.play_last) ? '0 : rd_idx_q + 1'b1;

    always_comb begin
        state_d  = state_q;
        rd_idx_d = rd_idx_q;
        case (state_q)
            PLAY_IDLE: begin
                // Index sits at 0 here, entry 0 goes out first
                if (ctrl_i.play_en) begin
                    state_d  = PLAY_RUN;
                    rd_idx_d = rd_idx_next;
                end
            end
            PLAY_RUN: begin
                if (!ctrl_i.play_en) begin
                    state_d  = PLAY_IDLE;
                    rd_idx_d = '0;
                end else begin
                    rd_idx_d = rd_idx_next;
                end
            end
            default: begin
                state_d  = PLAY_IDLE;
                rd_idx_d = '0;
            end
        endcase
    end

    // Zero whenever the sequencer is not running
    assign sample_d = (state_d == PLAY_RUN) ? mem[rd_idx_q] : '0;

    always_ff @(posedge dac_clk_out or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q      <= PLAY_IDLE;
            rd_idx_q     <= '0;
            awg_sample_o <= '0;
        end else begin
            state_q      <= state_d;
            rd_idx_q     <= rd_idx_d;
            awg_sample_o <= sample_d;
        end
    end

endmodule

`default_nettype wire

/* common/awg_ctrl_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface awg_ctrl_if import dac_pkg::*; ();

    // Sample memory write port
    // Single cycle strobe per bus write
    logic      wr_en;
    awg_addr_t wr_addr;
    dac_word_t wr_data;

    // Playback control
    logic      play_en;
    // Index of the last sample in the loop
    awg_addr_t play_last;

    // Register slave side
    modport regs_mp (
        output wr_en, wr_addr, wr_data,
        output play_en, play_last
    );

    // Waveform buffer side
    modport buf_mp (
        input  wr_en, wr_addr, wr_data,
        input  play_en, play_last
    );

endinterface

`default_nettype wire

/* common/dac_config.svh */
`ifndef DAC_CONFIG_SVH
`define DAC_CONFIG_SVH

// Data path widths
`define DAC_W       14
`define DSP_W       16

// Sample memory index width, 256 entries
`define AWG_ADDR_W  8

// Wishbone word address and data widths
`define WB_ADR_W    10
`define WB_DAT_W    32

// ------------------------------------------------
// Register map, word addresses
// ------------------------------------------------
`define REG_CTRL      10'h000
`define REG_LENGTH    10'h001
// First sample word, window spans 256 words
`define AWG_MEM_BASE  10'h100

// Control register bit positions
// Source bit set selects the waveform, clear selects DSP
`define CTRL_BIT_DAC0_EN   0
`define CTRL_BIT_DAC0_SRC  1
`define CTRL_BIT_DAC1_EN   2
`define CTRL_BIT_DAC1_SRC  3
`define CTRL_BIT_PLAY      4

`endif

/* common/dac_pkg.sv */
`default_nettype none

`include "dac_config.svh"

package dac_pkg;

    // One DAC code
    typedef logic [`DAC_W-1:0] dac_word_t;

    // One external DSP sample
    typedef logic [`DSP_W-1:0] dsp_word_t;

    // Index into the waveform memory
    typedef logic [`AWG_ADDR_W-1:0] awg_addr_t;

    // Wishbone word address and data word
    typedef logic [`WB_ADR_W-1:0] wb_addr_t;
    typedef logic [`WB_DAT_W-1:0] wb_data_t;

    // Playback sequencer states
    typedef enum logic {
        PLAY_IDLE,
        PLAY_RUN
    } play_state_t;

endpackage

`default_nettype wire

/* common/dac_route_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dac_route_if ();

    // Per channel output enable
    logic dac0_en;
    logic dac1_en;
    // Per channel source, high picks the waveform
    logic dac0_src_awg;
    logic dac1_src_awg;

    // Register slave side
    modport regs_mp (
        output dac0_en, dac0_src_awg, dac1_en, dac1_src_awg
    );

    // Output multiplexer side
    modport mux_mp (
        input  dac0_en, dac0_src_awg, dac1_en, dac1_src_awg
    );

endinterface

`default_nettype wire

/* design/dac_bist_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dac_bist_top import dac_pkg::*; (
    input  wire           dac_clk_out,
    input  wire           rst_n_i,
    // Wishbone classic slave
    input  wire           wb_cyc_i,
    input  wire           wb_stb_i,
    input  wire           wb_we_i,
    input  wire wb_addr_t wb_adr_i,
    input  wire wb_data_t wb_dat_i,
    output wb_data_t      wb_dat_o,
    output logic          wb_ack_o,
    // External DSP samples
    input  wire dsp_word_t dsp_i_i,
    input  wire dsp_word_t dsp_q_i,
    // DAC channel outputs
    output dac_word_t     dac0_o,
    output dac_word_t     dac1_o
);

    dac_word_t awg_sample;

    // Register to buffer, register to mux
    awg_ctrl_if  awg_ctrl ();
    dac_route_if dac_route ();

    // ------------------------------------------------
    // Producer, bus register slave
    // ------------------------------------------------
    awg_bus_regs u_regs (
        .dac_clk_out (dac_clk_out),
        .rst_n_i     (rst_n_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .ctrl_o      (awg_ctrl.regs_mp),
        .route_o     (dac_route.regs_mp)
    );

    // Buffer, waveform memory and sequencer
    awg_sample_buffer u_buf (
        .dac_clk_out  (dac_clk_out),
        .rst_n_i      (rst_n_i),
        .ctrl_i       (awg_ctrl.buf_mp),
        .awg_sample_o (awg_sample)
    );

    // Consumer, source mux and output registers
    dac_frame_mux u_mux (
        .dac_clk_out  (dac_clk_out),
        .rst_n_i      (rst_n_i),
        .route_i      (dac_route.mux_mp),
        .awg_sample_i (awg_sample),
        .dsp_i_i      (dsp_i_i),
        .dsp_q_i      (dsp_q_i),
        .dac0_o       (dac0_o),
        .dac1_o       (dac1_o)
    );

endmodule

`default_nettype wire

/* design/dac_frame_mux.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dac_config.svh"

module dac_frame_mux import dac_pkg::*; (
    input  wire            dac_clk_out,
    input  wire            rst_n_i,
    dac_route_if.mux_mp    route_i,
    input  wire dac_word_t awg_sample_i,
    input  wire dsp_word_t dsp_i_i,
    input  wire dsp_word_t dsp_q_i,
    output dac_word_t      dac0_o,
    output dac_word_t      dac1_o
);

    dac_word_t dac0_d;
    dac_word_t dac1_d;

    // Pick waveform or DSP, then gate with the enable
    // DSP keeps its top bits, the LSBs are dropped
    function automatic dac_word_t pick_source(
        input logic      en,
        input logic      src_awg,
        input dac_word_t awg,
        input dsp_word_t dsp
    );
        if (!en) begin
            return '0;
        end
        return src_awg ? awg : dsp[`DSP_W-1 -: `DAC_W];
    endfunction

    // Channel 0 follows I, channel 1 follows Q
    assign dac0_d = pick_source(route_i.dac0_en, route_i.dac0_src_awg, awg_sample_i, dsp_i_i);
    assign dac1_d = pick_source(route_i.dac1_en, route_i.dac1_src_awg, awg_sample_i, dsp_q_i);

    // ------------------------------------------------
    // Output registers toward the DAC pins
    // ------------------------------------------------
    always_ff @(posedge dac_clk_out or negedge rst_n_i) begin
        if (!rst_n_i) begin
            dac0_o <= '0;
            dac1_o <= '0;
        end else begin
            dac0_o <= dac0_d;
            dac1_o <= dac1_d;
        end
    end

endmodule

`default_nettype wire

/* files.f */
+incdir+common
common/dac_pkg.sv
common/awg_ctrl_if.sv
common/dac_route_if.sv
awg/awg_bus_regs.sv
awg/awg_sample_buffer.sv
design/dac_frame_mux.sv
design/dac_bist_top.sv
tb/dac_bist_tb.sv

/* tb/dac_bist_tb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dac_config.svh"

module dac_bist_tb import dac_pkg::*; ();

    localparam int RESET_CYCLES = 10;
    localparam int ACK_LIMIT    = 16;
    localparam int REG_TRIALS   = 16;
    localparam int DSP_CYCLES   = 64;
    localparam int PLAY_CYCLES  = 200;
    localparam int MIX_CYCLES   = 100;
    // Bus operations in fill, register trials, waveform load and control writes
    localparam int BUS_OPS      = 300 + REG_TRIALS * 8 + 64;
    // Three clocks per bus operation leaves slack
    localparam int TOTAL_CYCLES = RESET_CYCLES + BUS_OPS * 3 + DSP_CYCLES * 2
                                  + PLAY_CYCLES + MIX_CYCLES + 40;
    // Twice the expected length as margin
    localparam int WATCHDOG_NS  = TOTAL_CYCLES * 10 * 2;

    logic      dac_clk_out;
    logic      rst_n_i;
    logic      wb_cyc_i;
    logic      wb_stb_i;
    logic      wb_we_i;
    wb_addr_t  wb_adr_i;
    wb_data_t  wb_dat_i;
    wb_data_t  wb_dat_o;
    logic      wb_ack_o;
    dsp_word_t dsp_i_i;
    dsp_word_t dsp_q_i;
    dac_word_t dac0_o;
    dac_word_t dac1_o;

    integer    seed;
    int        cycle = 0;
    int        ack_cycle;
    int        check_errors = 0;
    int        output_errors = 0;
    logic      live_check;

    // Reference model state
    logic [`CTRL_BIT_PLAY:0] m_ctrl;
    awg_addr_t               m_last;
    dac_word_t               m_mem [1 << `AWG_ADDR_W];
    logic                    m_run;
    awg_addr_t               m_idx;
    dac_word_t               m_awg;
    dac_word_t               exp_dac0;
    dac_word_t               exp_dac1;

    dac_bist_top dut0 (
        .dac_clk_out (dac_clk_out),
        .rst_n_i     (rst_n_i),
        .wb_cyc_i    (wb_cyc_i),
        .wb_stb_i    (wb_stb_i),
        .wb_we_i     (wb_we_i),
        .wb_adr_i    (wb_adr_i),
        .wb_dat_i    (wb_dat_i),
        .wb_dat_o    (wb_dat_o),
        .wb_ack_o    (wb_ack_o),
        .dsp_i_i     (dsp_i_i),
        .dsp_q_i     (dsp_q_i),
        .dac0_o      (dac0_o),
        .dac1_o      (dac1_o)
    );

    initial dac_clk_out = 1'b0;
    always #5 dac_clk_out = ~dac_clk_out;

    // ------------------------------------------------
    // Model helpers
    // ------------------------------------------------
    // Enable gate over waveform or top DSP bits
    function automatic dac_word_t expected_channel(input logic en, input logic src_awg,
                                                   input dac_word_t awg, input dsp_word_t dsp);
        dac_word_t val;
        val = src_awg ? awg : dsp[`DSP_W-1:`DSP_W-`DAC_W];
        return en ? val : '0;
    endfunction

    function automatic wb_data_t expected_read(input wb_addr_t adr);
        if (adr == `REG_CTRL) begin
            return wb_data_t'(m_ctrl);
        end
        if (adr == `REG_LENGTH) begin
            return wb_data_t'(m_last);
        end
        // Sample window and unmapped space
        return '0;
    endfunction

    // Register map as seen from the bus with the window at 0x100 to 0x1FF
    function automatic void record_write(input wb_addr_t adr, input wb_data_t dat);
        if (adr == `REG_CTRL) begin
            m_ctrl = dat[`CTRL_BIT_PLAY:0];
        end else if (adr == `REG_LENGTH) begin
            m_last = dat[`AWG_ADDR_W-1:0];
        end else if (adr >= `AWG_MEM_BASE && adr <= 10'h1FF) begin
            m_mem[adr[`AWG_ADDR_W-1:0]] = dat[`DAC_W-1:0];
        end
    endfunction

    function automatic wb_data_t ctrl_word(input logic en0, input logic src0, input logic en1,
                                           input logic src1, input logic play);
        wb_data_t w;
        w = '0;
        w[`CTRL_BIT_DAC0_EN]  = en0;
        w[`CTRL_BIT_DAC0_SRC] = src0;
        w[`CTRL_BIT_DAC1_EN]  = en1;
        w[`CTRL_BIT_DAC1_SRC] = src1;
        w[`CTRL_BIT_PLAY]     = play;
        return w;
    endfunction

    // One clock then new DSP samples 1 ns after the edge
    task automatic next_cycle();
        @(posedge dac_clk_out);
        #1;
        cycle++;
        dsp_i_i = dsp_word_t'($random(seed));
        dsp_q_i = dsp_word_t'($random(seed));
    endtask

    // ------------------------------------------------
    // Wishbone classic master
    // ------------------------------------------------
    task automatic bus_cycle(input logic we, input wb_addr_t adr, input wb_data_t dat,
                             output wb_data_t rdat);
        int waited;
        waited   = 0;
        wb_cyc_i = 1'b1;
        wb_stb_i = 1'b1;
        wb_we_i  = we;
        wb_adr_i = adr;
        wb_dat_i = dat;
        do begin
            next_cycle();
            waited++;
        end while (!wb_ack_o && waited < ACK_LIMIT);
        assert (wb_ack_o) else begin
            check_errors++;
            $display("Bus request to address %h was never acknowledged", adr);
        end
        // Ack belongs on the first edge after the request
        assert (!wb_ack_o || waited == 1) else begin
            check_errors++;
            $display("[ERROR] %0t: ack for %h after %0d cycles, expected 1", $time, adr,
                     waited);
        end
        // Register takes effect on the ack edge
        ack_cycle = cycle;
        rdat      = wb_dat_o;
        if (we && wb_ack_o) begin
            record_write(adr, dat);
        end
        wb_cyc_i = 1'b0;
        wb_stb_i = 1'b0;
        wb_we_i  = 1'b0;
        next_cycle();
        assert (!wb_ack_o) else begin
            check_errors++;
            $display("[ERROR] %0t: ack held longer than one cycle at %h", $time, adr);
        end
    endtask

    task automatic bus_write(input wb_addr_t adr, input wb_data_t dat);
        wb_data_t unused;
        bus_cycle(1'b1, adr, dat, unused);
    endtask

    task automatic bus_read(input wb_addr_t adr);
        wb_data_t want;
        wb_data_t got;
        want = expected_read(adr);
        bus_cycle(1'b0, adr, '0, got);
        assert (got == want) else begin
            check_errors++;
            $display("[ERROR] %0t: read of %h gave %h, expected %h", $time, adr, got, want);
        end
    endtask

    // ------------------------------------------------
    // Cycle model and output monitor
    // ------------------------------------------------
    // Uses state from before the edge as the DUT registers do
    always @(posedge dac_clk_out) begin
        if (!rst_n_i) begin
            m_run    = 1'b0;
            m_idx    = '0;
            m_awg    = '0;
            exp_dac0 = '0;
            exp_dac1 = '0;
        end else begin
            // Mux stage sees the previous buffer sample
            exp_dac0 = expected_channel(m_ctrl[`CTRL_BIT_DAC0_EN], m_ctrl[`CTRL_BIT_DAC0_SRC],
                                        m_awg, dsp_i_i);
            exp_dac1 = expected_channel(m_ctrl[`CTRL_BIT_DAC1_EN], m_ctrl[`CTRL_BIT_DAC1_SRC],
                                        m_awg, dsp_q_i);
            if (!m_ctrl[`CTRL_BIT_PLAY]) begin
                m_run = 1'b0;
                m_idx = '0;
                m_awg = '0;
            end else begin
                // First edge with play high emits entry 0
                if (!m_run) begin
                    m_run = 1'b1;
                    m_idx = '0;
                end
                m_awg = m_mem[m_idx];
                // Past the last entry the loop restarts
                m_idx = (m_idx >= m_last) ? '0 : m_idx + 1'b1;
            end
        end
    end

    // Outputs settle between edges
    always @(negedge dac_clk_out) begin
        if (live_check) begin
            assert (dac0_o == exp_dac0) else begin
                output_errors++;
                $display("[ERROR] %0t: dac0_o is %h, expected %h", $time, dac0_o, exp_dac0);
            end
            assert (dac1_o == exp_dac1) else begin
                output_errors++;
                $display("[ERROR] %0t: dac1_o is %h, expected %h", $time, dac1_o, exp_dac1);
            end
        end
    end

    // Hang guard
    initial begin
        #(WATCHDOG_NS);
        $display("Run did not finish within %0d ns, stopping", WATCHDOG_NS);
        $display("tests failed");
        $finish;
    end

    // ------------------------------------------------
    // Test sequence
    // ------------------------------------------------
    initial begin
        wb_addr_t  adr;
        wb_data_t  val;
        dsp_word_t prev_i;
        dsp_word_t prev_q;
        int        k;
        int        last;
        int        start;
        seed       = 15;
        rst_n_i    = 1'b0;
        wb_cyc_i   = 1'b0;
        wb_stb_i   = 1'b0;
        wb_we_i    = 1'b0;
        wb_adr_i   = '0;
        wb_dat_i   = '0;
        dsp_i_i    = '0;
        dsp_q_i    = '0;
        live_check = 1'b0;
        m_ctrl     = '0;
        m_last     = '0;
        repeat (RESET_CYCLES) next_cycle();
        rst_n_i    = 1'b1;
        live_check = 1'b1;

        // Reset values
        assert (dac0_o == '0 && dac1_o == '0) else begin
            check_errors++;
            $display("[ERROR] %0t: outputs not zero after reset", $time);
        end
        bus_read(`REG_CTRL);
        bus_read(`REG_LENGTH);

        // Known contents in every entry from a pattern over the whole index
        for (int i = 0; i < (1 << `AWG_ADDR_W); i++) begin
            bus_write(wb_addr_t'(`AWG_MEM_BASE + i), wb_data_t'({i[7:0], ~i[7:2]}));
        end

        // Register readback plus window and unmapped space
        repeat (REG_TRIALS) begin
            val = $random(seed);
            bus_write(`REG_CTRL, val);
            val = $random(seed);
            bus_write(`REG_LENGTH, val);
            adr = (wb_addr_t'($random(seed)) & 10'h0FF) | 10'h002;
            bus_write(adr, $random(seed));
            bus_read(`REG_CTRL);
            bus_read(`REG_LENGTH);
            bus_read(wb_addr_t'(`AWG_MEM_BASE + ($random(seed) & 255)));
            bus_read(adr);
            bus_read(wb_addr_t'($random(seed)) | 10'h200);
        end
        bus_write(`REG_CTRL, '0);

        // DSP path with one cycle latency on both channels
        bus_write(`REG_CTRL, ctrl_word(1'b1, 1'b0, 1'b1, 1'b0, 1'b0));
        for (k = 0; k < DSP_CYCLES; k++) begin
            prev_i = dsp_i_i;
            prev_q = dsp_q_i;
            next_cycle();
            assert (dac0_o == prev_i[`DSP_W-1:`DSP_W-`DAC_W]
                    && dac1_o == prev_q[`DSP_W-1:`DSP_W-`DAC_W]) else begin
                check_errors++;
                $display("[ERROR] %0t: DSP samples not on outputs after one cycle", $time);
            end
        end
        bus_write(`REG_CTRL, ctrl_word(1'b0, 1'b0, 1'b1, 1'b0, 1'b0));
        repeat (DSP_CYCLES / 4) next_cycle();
        assert (dac0_o == '0) else begin
            check_errors++;
            $display("[ERROR] %0t: disabled dac0_o is %h", $time, dac0_o);
        end
        bus_write(`REG_CTRL, '0);

        // Waveform playback on channel 0
        last = $random(seed) & 63;
        for (int i = 0; i <= last; i++) begin
            bus_write(wb_addr_t'(`AWG_MEM_BASE + i), $random(seed));
        end
        bus_write(`REG_LENGTH, wb_data_t'(last));
        bus_write(`REG_CTRL, ctrl_word(1'b1, 1'b1, 1'b0, 1'b0, 1'b1));
        start = ack_cycle;
        for (k = 0; k < PLAY_CYCLES; k++) begin
            while (cycle < start + 2 + k) begin
                next_cycle();
            end
            assert (dac0_o == m_mem[k % (last + 1)]) else begin
                check_errors++;
                $display("[ERROR] %0t: sample %0d is %h, expected %h", $time, k, dac0_o,
                         m_mem[k % (last + 1)]);
            end
        end

        // Mixed routing with channel 1 on Q while the loop keeps running
        bus_write(`REG_CTRL, ctrl_word(1'b1, 1'b1, 1'b1, 1'b0, 1'b1));
        for (k = 0; k < MIX_CYCLES; k++) begin
            prev_q = dsp_q_i;
            next_cycle();
            assert (dac1_o == prev_q[`DSP_W-1:`DSP_W-`DAC_W]) else begin
                check_errors++;
                $display("[ERROR] %0t: dac1_o is %h during playback", $time, dac1_o);
            end
        end

        // Stop then channel 0 goes quiet two cycles after ack
        bus_write(`REG_CTRL, ctrl_word(1'b1, 1'b1, 1'b1, 1'b0, 1'b0));
        start = ack_cycle;
        while (cycle < start + 2) begin
            next_cycle();
        end
        repeat (20) begin
            assert (dac0_o == '0) else begin
                check_errors++;
                $display("[ERROR] %0t: dac0_o is %h after stop", $time, dac0_o);
            end
            next_cycle();
        end

        repeat (4) next_cycle();
        $display("Errors: %0d directed, %0d cycle model", check_errors, output_errors);
        if (check_errors == 0 && output_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
